// ==== files.f ====
logic/cpuPkg.sv
logic/regFile.sv
logic/insnDecoder.sv
logic/operandShuffle.sv
logic/aluExec.sv
logic/cpuCore.sv
logic/sharedMemory.sv
logic/cpuSystem.sv
sim/cpuSystem_tb.sv

// ==== sim/cpuSystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem_tb;

    localparam int          MEM_ADDR_BITS = 10;
    localparam int          TEST_PERIODS  = 64 + 8 + 10;   // Main run, throw run, trap run
    localparam int          LIMIT_CYCLES  = TEST_PERIODS * 8 + 200;
    localparam logic [31:0] PROG_BASE     = cpuPkg::RESET_VECTOR;
    localparam logic [31:0] THROW_HANDLER = 32'h0000_0060;
    localparam logic [31:0] SENTINEL      = 32'h5A5A_5A5A;
    localparam logic [11:0] TRAP_MARK     = 12'h2A5;
    localparam logic [11:0] THROW_MARK    = 12'h35A;

    logic        clk;
    logic        reset_n;
    logic        halt;
    logic        trap;
    logic        hostWe;
    logic [31:0] hostAddr;
    logic [31:0] hostWdata;
    wire  [31:0] hostRdata;

    logic [31:0] prog [$];      // Program image, written out by loadProgram
    logic [11:0] cImm [0:15];
    logic [11:0] kImm;
    logic [31:0] valA, valB, shAmt, valD, rnd, yVal, pcRead;
    logic [3:0]  opSel, yReg;
    int          mainLen;
    integer      seed;
    int          errors;
    int          checks;

    cpuSystem #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .halt      (halt),
        .trap      (trap),
        .hostWe    (hostWe),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .hostRdata (hostRdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction word: kind, store, deref, Z, X, Y, op, imm from the top bit down
    function automatic logic [31:0] encode(input logic [1:0] kind, input logic st,
                                           input logic dr, input logic [3:0] z,
                                           input logic [3:0] x, input logic [3:0] y,
                                           input logic [3:0] op, input logic [11:0] imm);
        return {kind, st, dr, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] throwWord(input logic [4:0] vector);
        return {cpuPkg::KIND_THROW, 25'd0, vector};
    endfunction

    // X = Y = r0, so the immediate alone is the address or value
    function automatic logic [31:0] loadFrom(input logic [3:0] z, input logic [11:0] addr);
        return encode(cpuPkg::KIND_XYI, 1'b0, 1'b1, z, 4'd0, 4'd0, cpuPkg::OP_ADD, addr);
    endfunction

    function automatic logic [31:0] storeTo(input logic [3:0] z, input logic [11:0] addr);
        return encode(cpuPkg::KIND_XYI, 1'b1, 1'b1, z, 4'd0, 4'd0, cpuPkg::OP_ADD, addr);
    endfunction

    function automatic logic [31:0] setReg(input logic [3:0] z, input logic [11:0] value);
        return encode(cpuPkg::KIND_XYI, 1'b0, 1'b0, z, 4'd0, 4'd0, cpuPkg::OP_ADD, value);
    endfunction

    // New PC = own address + 1 + offset, so -1 spins in place
    function automatic logic [31:0] jumpBy(input logic [11:0] offset);
        return encode(cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, cpuPkg::OP_ADD, offset);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic usesShift(input logic [3:0] op);
        return op == cpuPkg::OP_SHL || op == cpuPkg::OP_SHR || op == cpuPkg::OP_SAR;
    endfunction

    // Reference model: signed 32-bit operation, true compares are all ones, then plus C
    function automatic logic [31:0] expectedAlu(input logic [3:0] op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [31:0] c);
        logic        [31:0] r;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            cpuPkg::OP_OR:   r = a | b;
            cpuPkg::OP_AND:  r = a & b;
            cpuPkg::OP_ADD:  r = a + b;
            cpuPkg::OP_MUL:  r = a * b;
            cpuPkg::OP_SHL:  r = (b < 32) ? a << b[4:0] : 32'd0;
            cpuPkg::OP_LT:   r = (sa < sb) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::OP_EQ:   r = (a == b) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::OP_GE:   r = (sa >= sb) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::OP_ANDN: r = a & ~b;
            cpuPkg::OP_XOR:  r = a ^ b;
            cpuPkg::OP_SUB:  r = a - b;
            cpuPkg::OP_XNOR: r = ~(a ^ b);
            cpuPkg::OP_SHR:  r = (b < 32) ? a >> b[4:0] : 32'd0;
            cpuPkg::OP_NE:   r = (a != b) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::OP_SAR:  r = (b < 32) ? sa >>> b[4:0] : $signed({32{a[31]}});
            default:         r = 'x;
        endcase
        return r + c;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        hostWe    = 1'b1;
        hostAddr  = addr;
        hostWdata = data;
        waitCycles(1);
        hostWe    = 1'b0;
    endtask

    task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
        hostAddr = addr;
        waitCycles(1);   // One cycle read latency
        data = hostRdata;
    endtask

    task automatic checkWord(input logic [31:0] addr, input logic [31:0] expected,
                             input string what);
        logic [31:0] got;
        readWord(addr, got);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED t=%0t hostRdata[%h] (%s): expected %h, actual %h",
                     $time, addr, what, expected, got);
        end
    endtask

    task automatic loadProgram(input logic [31:0] base);
        foreach (prog[i]) begin
            writeWord(base + i, prog[i]);
        end
        prog.delete();
    endtask

    task automatic runProgram(input int periods);
        halt = 1'b0;
        waitCycles(periods * 8);
        halt = 1'b1;
        waitCycles(16);   // Let the core settle back in idle
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Errors: %0d in %0d checks", errors, checks);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed      = 12;
        errors    = 0;
        checks    = 0;
        reset_n   = 1'b0;
        halt      = 1'b1;
        trap      = 1'b0;
        hostWe    = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        waitCycles(4);
        reset_n = 1'b1;

        valA  = $random(seed);
        valB  = $random(seed);
        rnd   = $random(seed);
        shAmt = {27'd0, rnd[4:0]};   // Keeps shifts inside the word
        valD  = $random(seed);
        writeWord(32'h300, valA);
        writeWord(32'h301, valB);
        writeWord(32'h302, shAmt);
        writeWord(32'h303, valD);
        writeWord(32'h343, SENTINEL);
        writeWord(32'h346, SENTINEL);
        writeWord(32'h347, SENTINEL);

        prog.push_back(loadFrom(4'd1, 12'h300));
        prog.push_back(loadFrom(4'd2, 12'h301));
        prog.push_back(loadFrom(4'd5, 12'h302));
        for (int k = 0; k < 16; k++) begin   // Result of opcode k lands at 0x310 + k
            rnd     = $random(seed);
            cImm[k] = rnd[11:0];
            opSel   = k[3:0];
            yReg    = usesShift(opSel) ? 4'd5 : 4'd2;
            if (opSel != cpuPkg::OP_RSVD) begin
                prog.push_back(encode(cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd3, 4'd1, yReg,
                                      opSel, cImm[k]));
                prog.push_back(storeTo(4'd3, {8'h31, opSel}));
            end
        end
        rnd  = $random(seed);
        kImm = rnd[11:0];
        for (int k = 0; k < 3; k++) begin
            prog.push_back(encode(k[1:0], 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, cpuPkg::OP_SUB, kImm));
            prog.push_back(storeTo(4'd3, 12'h340 + k[11:0]));
        end
        prog.push_back(encode(cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd0, 4'd1, 4'd0,
                              cpuPkg::OP_ADD, 12'd5));   // Try to write r0
        prog.push_back(storeTo(4'd0, 12'h343));
        pcRead = PROG_BASE + prog.size();
        prog.push_back(encode(cpuPkg::KIND_XYI, 1'b0, 1'b0, 4'd6, 4'd15, 4'd0,
                              cpuPkg::OP_ADD, 12'd0));
        prog.push_back(storeTo(4'd6, 12'h344));
        prog.push_back(loadFrom(4'd7, 12'h303));
        prog.push_back(setReg(4'd8, 12'h345));
        prog.push_back(encode(cpuPkg::KIND_XYI, 1'b1, 1'b0, 4'd8, 4'd7, 4'd0,
                              cpuPkg::OP_ADD, 12'd0));   // Address from r8, data is r7
        prog.push_back(jumpBy(12'd1));
        prog.push_back(storeTo(4'd1, 12'h346));   // Skipped by the branch
        prog.push_back(storeTo(4'd1, 12'h347));
        prog.push_back(jumpBy(12'hFFF));
        mainLen = prog.size();
        loadProgram(PROG_BASE);
        runProgram(mainLen + 2);

        for (int k = 0; k < 16; k++) begin
            opSel = k[3:0];
            yVal  = usesShift(opSel) ? shAmt : valB;
            if (opSel != cpuPkg::OP_RSVD) begin
                checkWord({20'd0, 8'h31, opSel},
                          expectedAlu(opSel, valA, yVal, sext12(cImm[k])), "ALU opcode");
            end
        end
        checkWord(32'h340, expectedAlu(cpuPkg::OP_SUB, valA, valB, sext12(kImm)), "kind XYI");
        checkWord(32'h341, expectedAlu(cpuPkg::OP_SUB, valA, sext12(kImm), valB), "kind XIY");
        checkWord(32'h342, expectedAlu(cpuPkg::OP_SUB, sext12(kImm), valA, valB), "kind IXY");
        checkWord(32'h343, 32'd0, "register 0 after write");
        checkWord(32'h344, pcRead + 1, "register 15 read");
        checkWord(32'h345, valD, "load then store");
        checkWord(32'h346, SENTINEL, "store skipped by branch");
        checkWord(32'h347, valA, "store at branch target");

        // Handlers at the trampoline and at the vector 3 target
        prog.push_back(setReg(4'd9, TRAP_MARK));
        prog.push_back(storeTo(4'd9, 12'h350));
        prog.push_back(jumpBy(12'hFFF));
        loadProgram(cpuPkg::TRAMP_BOTTOM);
        prog.push_back(setReg(4'd9, THROW_MARK));
        prog.push_back(storeTo(4'd9, 12'h351));
        prog.push_back(jumpBy(12'hFFF));
        loadProgram(THROW_HANDLER);
        writeWord(cpuPkg::VECTOR_BASE | 32'd3, THROW_HANDLER);
        writeWord(cpuPkg::TRAP_ADDR, 32'd0);
        writeWord(32'h351, 32'd0);

        prog.push_back(setReg(4'd3, 12'h011));
        prog.push_back(throwWord(5'd3));
        loadProgram(PROG_BASE);
        runProgram(8);
        checkWord(32'h351, sext12(THROW_MARK), "throw handler marker");
        checkWord(cpuPkg::TRAP_ADDR, PROG_BASE + 1, "throw return address");

        writeWord(cpuPkg::TRAP_ADDR, 32'd0);
        writeWord(32'h350, 32'd0);
        prog.push_back(setReg(4'd3, 12'h022));
        prog.push_back(jumpBy(12'hFFF));
        loadProgram(PROG_BASE);
        halt = 1'b0;
        waitCycles(3 + 8 * 2);   // Shuffle of the second pass through the spin loop
        trap = 1'b1;
        waitCycles(1);
        trap = 1'b0;
        waitCycles(6 * 8);
        halt = 1'b1;
        waitCycles(16);
        checkWord(32'h350, sext12(TRAP_MARK), "trap handler marker");
        checkWord(cpuPkg::TRAP_ADDR, PROG_BASE + 1, "trap return address");

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cpuSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            halt,
    input  wire                            trap,
    input  wire                            hostWe,
    input  wire  [cpuPkg::WORD_BITS-1:0]   hostAddr,
    input  wire  [cpuPkg::WORD_BITS-1:0]   hostWdata,
    output logic [cpuPkg::WORD_BITS-1:0]   hostRdata
);

    logic [cpuPkg::WORD_BITS-1:0] iAddr, iData;
    logic [cpuPkg::WORD_BITS-1:0] dAddr, dWdata, dRdata;
    logic                         dStrobe, dWrite;

    cpuCore u_core (
        .clk     (clk),
        .reset_n (reset_n),
        .halt    (halt),
        .trap    (trap),
        .iAddr   (iAddr),
        .iData   (iData),
        .dStrobe (dStrobe),
        .dWrite  (dWrite),
        .dAddr   (dAddr),
        .dWdata  (dWdata),
        .dRdata  (dRdata)
    );

    sharedMemory #(
        .ADDR_BITS (MEM_ADDR_BITS)
    ) u_mem (
        .clk       (clk),
        .aAddr     (iAddr),
        .aData     (iData),
        .dStrobe   (dStrobe),
        .dWrite    (dWrite),
        .dAddr     (dAddr),
        .dWdata    (dWdata),
        .dRdata    (dRdata),
        .hostWe    (hostWe),
        .hostAddr  (hostAddr),
        .hostWdata (hostWdata),
        .hostRdata (hostRdata)
    );

endmodule

`default_nettype wire

// ==== logic/sharedMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module sharedMemory #(
    parameter int ADDR_BITS = 10
) (
    input  wire                            clk,
    // Core side
    input  wire  [cpuPkg::WORD_BITS-1:0]   aAddr,
    output logic [cpuPkg::WORD_BITS-1:0]   aData,
    input  wire                            dStrobe,
    input  wire                            dWrite,
    input  wire  [cpuPkg::WORD_BITS-1:0]   dAddr,
    input  wire  [cpuPkg::WORD_BITS-1:0]   dWdata,
    output logic [cpuPkg::WORD_BITS-1:0]   dRdata,
    // Host side
    input  wire                            hostWe,
    input  wire  [cpuPkg::WORD_BITS-1:0]   hostAddr,
    input  wire  [cpuPkg::WORD_BITS-1:0]   hostWdata,
    output logic [cpuPkg::WORD_BITS-1:0]   hostRdata
);

    logic [cpuPkg::WORD_BITS-1:0] mem [0:(1 << ADDR_BITS) - 1];

    always_ff @(posedge clk) begin
        if (dStrobe && dWrite)
            mem[dAddr[ADDR_BITS-1:0]] <= dWdata;
        if (hostWe)
            mem[hostAddr[ADDR_BITS-1:0]] <= hostWdata;   // Last write wins, so host has priority

        aData     <= mem[aAddr[ADDR_BITS-1:0]];
        dRdata    <= mem[dAddr[ADDR_BITS-1:0]];
        hostRdata <= mem[hostAddr[ADDR_BITS-1:0]];
    end

endmodule

`default_nettype wire

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            halt,
    input  wire                            trap,
    output logic [cpuPkg::WORD_BITS-1:0]   iAddr,
    input  wire  [cpuPkg::WORD_BITS-1:0]   iData,
    output logic                           dStrobe,
    output logic                           dWrite,
    output logic [cpuPkg::WORD_BITS-1:0]   dAddr,
    output logic [cpuPkg::WORD_BITS-1:0]   dWdata,
    input  wire  [cpuPkg::WORD_BITS-1:0]   dRdata
);

    localparam int W = cpuPkg::WORD_BITS;

    cpuPkg::seqState state;
    cpuPkg::insnWord insn;

    logic [W-1:0] nextPc;    // Address after the current instruction
    logic [W-1:0] rResult;
    logic [W-1:0] rData;
    logic [W-1:0] vAddr;     // Handler entry

    logic [cpuPkg::REG_IDX_BITS-1:0] idxZ, idxX, idxY;
    logic [cpuPkg::ALU_OP_BITS-1:0]  op;
    logic [cpuPkg::IMM_BITS-1:0]     imm;
    logic [cpuPkg::KIND_BITS-1:0]    kind;
    logic [cpuPkg::VECTOR_BITS-1:0]  vector;
    logic                            storing, derefRhs, throwInsn, branch;
    logic [W-1:0]                    valZ, valX, valY, nextZ;
    logic [W-1:0]                    opA, opB, opC, aluOut;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= cpuPkg::sIdle;
        end else begin
            case (state)
                cpuPkg::sIdle: begin
                    iAddr <= cpuPkg::RESET_VECTOR;
                    state <= halt ? cpuPkg::sIdle : cpuPkg::sNextPc;
                end
                cpuPkg::sShuffle: begin
                    if (halt)           state <= cpuPkg::sIdle;
                    else if (trap)      state <= cpuPkg::sTrapEntry;
                    else if (throwInsn) state <= cpuPkg::sThrow;
                    else                state <= cpuPkg::sExec;
                end
                cpuPkg::sExec:  state <= cpuPkg::sLatch;
                cpuPkg::sLatch: begin
                    rResult <= aluOut;
                    state   <= cpuPkg::sWait;
                end
                cpuPkg::sWait: state <= cpuPkg::sMem;   // Data address settles here
                cpuPkg::sMem: begin
                    rData <= dRdata;
                    state <= cpuPkg::sCommit;
                end
                cpuPkg::sCommit: begin
                    iAddr <= branch ? nextZ : nextPc;
                    state <= cpuPkg::sNextPc;
                end
                cpuPkg::sNextPc: begin
                    nextPc <= iAddr + 1'b1;
                    state  <= cpuPkg::sFetch;
                end
                cpuPkg::sFetch: begin
                    insn  <= iData;
                    state <= cpuPkg::sShuffle;
                end
                // Throw reads its table entry, trap goes to the trampoline
                cpuPkg::sThrow: state <= cpuPkg::sVector;
                cpuPkg::sVector: begin
                    vAddr <= dRdata;
                    state <= cpuPkg::sSaveRet;
                end
                cpuPkg::sTrapEntry: begin
                    vAddr <= cpuPkg::TRAMP_BOTTOM;
                    state <= cpuPkg::sSaveRet;
                end
                cpuPkg::sSaveRet: begin
                    rResult <= iAddr;   // Return address
                    state   <= cpuPkg::sTrapWrite;
                end
                cpuPkg::sTrapWrite: begin
                    iAddr <= vAddr;
                    state <= cpuPkg::sNextPc;
                end
                default: state <= cpuPkg::sIdle;
            endcase
        end
    end

    // Memory access in sMem, plus the table read and return address write
    assign dStrobe = (state == cpuPkg::sMem && (derefRhs || storing))
                   || state == cpuPkg::sThrow || state == cpuPkg::sTrapWrite;
    assign dWrite  = (state == cpuPkg::sMem && storing) || state == cpuPkg::sTrapWrite;

    always_comb begin
        if (state == cpuPkg::sThrow)
            dAddr = cpuPkg::VECTOR_BASE | W'(vector);
        else if (state == cpuPkg::sTrapWrite)
            dAddr = cpuPkg::TRAP_ADDR;
        else if (derefRhs)
            dAddr = rResult;
        else
            dAddr = valZ;
    end

    assign dWdata = (derefRhs && state != cpuPkg::sTrapWrite) ? valZ : rResult;
    assign nextZ  = derefRhs ? rData : rResult;   // Loads commit the fetched word

    insnDecoder u_decoder (
        .insn      (insn),
        .idxZ      (idxZ),
        .idxX      (idxX),
        .idxY      (idxY),
        .op        (op),
        .imm       (imm),
        .kind      (kind),
        .storing   (storing),
        .derefRhs  (derefRhs),
        .throwInsn (throwInsn),
        .branch    (branch),
        .vector    (vector)
    );

    regFile u_regs (
        .clk     (clk),
        .writeEn (state == cpuPkg::sCommit && !storing),
        .idxZ    (idxZ),
        .idxX    (idxX),
        .idxY    (idxY),
        .nextZ   (nextZ),
        .nextPc  (nextPc),
        .valZ    (valZ),
        .valX    (valX),
        .valY    (valY)
    );

    operandShuffle u_shuffle (
        .clk  (clk),
        .en   (state == cpuPkg::sShuffle),
        .kind (kind),
        .valX (valX),
        .valY (valY),
        .imm  (imm),
        .opA  (opA),
        .opB  (opB),
        .opC  (opC)
    );

    aluExec u_alu (
        .clk    (clk),
        .en     (state == cpuPkg::sExec),
        .op     (op),
        .opA    (opA),
        .opB    (opB),
        .opC    (opC),
        .result (aluOut)
    );

endmodule

`default_nettype wire

// ==== logic/aluExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExec (
    input  wire                                  clk,
    input  wire                                  en,
    input  wire         [cpuPkg::ALU_OP_BITS-1:0] op,
    input  wire  signed [cpuPkg::WORD_BITS-1:0]   opA,
    input  wire  signed [cpuPkg::WORD_BITS-1:0]   opB,
    input  wire  signed [cpuPkg::WORD_BITS-1:0]   opC,
    output logic        [cpuPkg::WORD_BITS-1:0]   result
);

    localparam int W = cpuPkg::WORD_BITS;

    // Comparisons give all ones for true, zero for false
    always_ff @(posedge clk) begin
        if (en) begin
            case (op)
                cpuPkg::OP_OR:   result <= (opA | opB) + opC;
                cpuPkg::OP_AND:  result <= (opA & opB) + opC;
                cpuPkg::OP_ADD:  result <= (opA + opB) + opC;
                cpuPkg::OP_MUL:  result <= (opA * opB) + opC;   // Low word only
                cpuPkg::OP_RSVD: result <= 'x;
                cpuPkg::OP_SHL:  result <= (opA << opB) + opC;
                cpuPkg::OP_LT:   result <= {W{opA < opB}} + opC;
                cpuPkg::OP_EQ:   result <= {W{opA == opB}} + opC;
                cpuPkg::OP_GE:   result <= {W{opA >= opB}} + opC;
                cpuPkg::OP_ANDN: result <= (opA & ~opB) + opC;
                cpuPkg::OP_XOR:  result <= (opA ^ opB) + opC;
                cpuPkg::OP_SUB:  result <= (opA - opB) + opC;
                cpuPkg::OP_XNOR: result <= (opA ^ ~opB) + opC;
                cpuPkg::OP_SHR:  result <= (opA >> opB) + opC;    // Zero fill
                cpuPkg::OP_NE:   result <= {W{opA != opB}} + opC;
                cpuPkg::OP_SAR:  result <= (opA >>> opB) + opC;   // Sign fill
                default:         result <= 'x;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/operandShuffle.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandShuffle (
    input  wire                              clk,
    input  wire                              en,
    input  wire  [cpuPkg::KIND_BITS-1:0]     kind,
    input  wire  [cpuPkg::WORD_BITS-1:0]     valX,
    input  wire  [cpuPkg::WORD_BITS-1:0]     valY,
    input  wire  [cpuPkg::IMM_BITS-1:0]      imm,
    output logic [cpuPkg::WORD_BITS-1:0]     opA,
    output logic [cpuPkg::WORD_BITS-1:0]     opB,
    output logic [cpuPkg::WORD_BITS-1:0]     opC
);

    logic [cpuPkg::WORD_BITS-1:0] immExt;

    assign immExt = {{(cpuPkg::WORD_BITS - cpuPkg::IMM_BITS){imm[cpuPkg::IMM_BITS-1]}}, imm};

    always_ff @(posedge clk) begin
        if (en) begin
            case (kind)
                cpuPkg::KIND_XYI: begin
                    opA <= valX;
                    opB <= valY;
                    opC <= immExt;
                end
                cpuPkg::KIND_XIY: begin
                    opA <= valX;
                    opB <= immExt;
                    opC <= valY;
                end
                cpuPkg::KIND_IXY: begin
                    opA <= immExt;
                    opB <= valX;
                    opC <= valY;
                end
                default: begin   // Throw, never executed
                    opA <= 'x;
                    opB <= 'x;
                    opC <= 'x;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/insnDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insnDecoder (
    input  wire cpuPkg::insnWord               insn,
    output logic [cpuPkg::REG_IDX_BITS-1:0]    idxZ,
    output logic [cpuPkg::REG_IDX_BITS-1:0]    idxX,
    output logic [cpuPkg::REG_IDX_BITS-1:0]    idxY,
    output logic [cpuPkg::ALU_OP_BITS-1:0]     op,
    output logic [cpuPkg::IMM_BITS-1:0]        imm,
    output logic [cpuPkg::KIND_BITS-1:0]       kind,
    output logic                               storing,
    output logic                               derefRhs,
    output logic                               throwInsn,
    output logic                               branch,
    output logic [cpuPkg::VECTOR_BITS-1:0]     vector
);

    // Operate view
    assign kind     = insn.oper.kind;
    assign storing  = insn.oper.storing;
    assign derefRhs = insn.oper.derefRhs;
    assign idxZ     = insn.oper.z;
    assign idxX     = insn.oper.x;
    assign idxY     = insn.oper.y;
    assign op       = insn.oper.op;
    assign imm      = insn.oper.imm;

    // Throw view
    assign vector    = insn.thr.vector;
    assign throwInsn = (insn.thr.kind == cpuPkg::KIND_THROW);

    assign branch = (&idxZ) && !storing;   // Result goes to the PC

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                              clk,
    input  wire                              writeEn,
    input  wire  [cpuPkg::REG_IDX_BITS-1:0]  idxZ,
    input  wire  [cpuPkg::REG_IDX_BITS-1:0]  idxX,
    input  wire  [cpuPkg::REG_IDX_BITS-1:0]  idxY,
    input  wire  [cpuPkg::WORD_BITS-1:0]     nextZ,
    input  wire  [cpuPkg::WORD_BITS-1:0]     nextPc,
    output logic [cpuPkg::WORD_BITS-1:0]     valZ,
    output logic [cpuPkg::WORD_BITS-1:0]     valX,
    output logic [cpuPkg::WORD_BITS-1:0]     valY
);

    logic [cpuPkg::WORD_BITS-1:0] store [0:14];

    initial store[0] = '0;   // Zero register, never written

    // Index 15 is the program counter
    assign valZ = (&idxZ) ? nextPc : store[idxZ];
    assign valX = (&idxX) ? nextPc : store[idxX];
    assign valY = (&idxY) ? nextPc : store[idxY];

    always_ff @(posedge clk) begin
        if (writeEn && (|idxZ) && !(&idxZ)) begin
            store[idxZ] <= nextZ;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int WORD_BITS    = 32;
    localparam int REG_IDX_BITS = 4;
    localparam int IMM_BITS     = 12;
    localparam int ALU_OP_BITS  = 4;
    localparam int KIND_BITS    = 2;
    localparam int VECTOR_BITS  = 5;

    // ALU function codes, every result gets operand C added
    localparam logic [ALU_OP_BITS-1:0] OP_OR   = 4'h0;
    localparam logic [ALU_OP_BITS-1:0] OP_AND  = 4'h1;
    localparam logic [ALU_OP_BITS-1:0] OP_ADD  = 4'h2;
    localparam logic [ALU_OP_BITS-1:0] OP_MUL  = 4'h3;
    localparam logic [ALU_OP_BITS-1:0] OP_RSVD = 4'h4;
    localparam logic [ALU_OP_BITS-1:0] OP_SHL  = 4'h5;
    localparam logic [ALU_OP_BITS-1:0] OP_LT   = 4'h6;
    localparam logic [ALU_OP_BITS-1:0] OP_EQ   = 4'h7;
    localparam logic [ALU_OP_BITS-1:0] OP_GE   = 4'h8;
    localparam logic [ALU_OP_BITS-1:0] OP_ANDN = 4'h9;
    localparam logic [ALU_OP_BITS-1:0] OP_XOR  = 4'hA;
    localparam logic [ALU_OP_BITS-1:0] OP_SUB  = 4'hB;
    localparam logic [ALU_OP_BITS-1:0] OP_XNOR = 4'hC;
    localparam logic [ALU_OP_BITS-1:0] OP_SHR  = 4'hD;
    localparam logic [ALU_OP_BITS-1:0] OP_NE   = 4'hE;
    localparam logic [ALU_OP_BITS-1:0] OP_SAR  = 4'hF;

    // Operand order, named as A B C
    localparam logic [KIND_BITS-1:0] KIND_XYI   = 2'd0;
    localparam logic [KIND_BITS-1:0] KIND_XIY   = 2'd1;
    localparam logic [KIND_BITS-1:0] KIND_IXY   = 2'd2;
    localparam logic [KIND_BITS-1:0] KIND_THROW = 2'd3;

    typedef enum logic [3:0] {
        sIdle, sShuffle, sExec, sLatch, sWait, sMem, sCommit, sNextPc, sFetch,
        sThrow, sTrapEntry, sVector, sSaveRet, sTrapWrite
    } seqState;

    localparam logic [WORD_BITS-1:0] RESET_VECTOR = 32'h0000_0100;
    localparam logic [WORD_BITS-1:0] VECTOR_BASE  = 32'h0000_0020;
    localparam logic [WORD_BITS-1:0] TRAMP_BOTTOM = 32'h0000_0040;
    localparam logic [WORD_BITS-1:0] TRAP_ADDR    = 32'h0000_001F;

    typedef struct packed {
        logic [KIND_BITS-1:0]    kind;
        logic                    storing;
        logic                    derefRhs;
        logic [REG_IDX_BITS-1:0] z;
        logic [REG_IDX_BITS-1:0] x;
        logic [REG_IDX_BITS-1:0] y;
        logic [ALU_OP_BITS-1:0]  op;
        logic [IMM_BITS-1:0]     imm;
    } operateView;

    typedef struct packed {
        logic [KIND_BITS-1:0]                         kind;
        logic [WORD_BITS-KIND_BITS-VECTOR_BITS-1:0]   unused;
        logic [VECTOR_BITS-1:0]                       vector;
    } throwView;

    typedef union packed {
        operateView oper;
        throwView   thr;
    } insnWord;

endpackage

`default_nettype wire
